// ==== sources.f ====
+incdir+include
hw/regcluster_pkg.sv
hw/regPortIf.sv
hw/instrDecode.sv
hw/regBank.sv
hw/aluWriteback.sv
hw/regCluster.sv
verif/regCluster_sva.sv
verif/regCluster_tb.sv

// ==== Bender.yml ====
package:
  name: regcluster

export_include_dirs:
  - include

sources:
  - files:
      - hw/regcluster_pkg.sv
      - hw/regPortIf.sv
      - hw/instrDecode.sv
      - hw/regBank.sv
      - hw/aluWriteback.sv
      - hw/regCluster.sv
  - target: test
    include_dirs:
      - include
    files:
      - verif/regCluster_sva.sv
      - verif/regCluster_tb.sv

// ==== verif/regCluster_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "regcluster_config.svh"

module regCluster_tb;

    localparam int CLOCK_PERIOD = 20;
    localparam int DRIVE_DELAY  = 2;
    localparam int RESET_CYCLES = 4;
    localparam logic [31:0] SEED = 32'h4d3e399f;

    // Stack pointer value after reset
    localparam logic [31:0] STACK_VALUE = 32'd54400;

    // MIPS encodings of the supported subset
    localparam logic [5:0] OPC_RTYPE = 6'h00;
    localparam logic [5:0] OPC_ADDI  = 6'h08;
    localparam logic [5:0] OPC_ORI   = 6'h0d;
    localparam logic [5:0] OPC_LW    = 6'h23;
    localparam logic [5:0] FN_ADD    = 6'h20;
    localparam logic [5:0] FN_SUB    = 6'h22;
    localparam logic [5:0] FN_AND    = 6'h24;
    localparam logic [5:0] FN_OR     = 6'h25;
    localparam logic [5:0] FN_NOR    = 6'h27;
    localparam logic [5:0] FN_SLT    = 6'h2a;

    // Run length, used for the timeout
    localparam int DIRECTED_COUNT = 20;
    localparam int RANDOM_COUNT   = 400;
    localparam int SWEEP_COUNT    = 4;
    localparam int DRAIN_CYCLES   = 3;
    // Random gaps can at most double the stream
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + DIRECTED_COUNT + 2 * RANDOM_COUNT
        + SWEEP_COUNT * (`REG_COUNT + 1) + SWEEP_COUNT * DRAIN_CYCLES + 40;

    logic                       Clock = 1'b0;
    logic                       rstN;
    logic                       instrValid;
    logic [31:0]                instr;
    logic [`REG_ADDR_WIDTH-1:0] dbgAddr;
    logic [`DATA_WIDTH-1:0]     result;
    logic [`REG_ADDR_WIDTH-1:0] resultDest;
    logic                       resultValid;
    logic [`DATA_WIDTH-1:0]     dbgData;

    // Reference register file
    logic [31:0] modelRegs [32];

    // Expectation driven together with each instruction
    logic [31:0] expResult = '0;
    logic [4:0]  expDest = '0;
    logic        destKnown = 1'b0;
    // Same values two sampling edges later, lined up with resultValid
    logic [31:0] expResultD1 = '0;
    logic [31:0] expResultD2 = '0;
    logic [4:0]  expDestD1 = '0;
    logic [4:0]  expDestD2 = '0;
    logic        destKnownD1 = 1'b0;
    logic        destKnownD2 = 1'b0;
    logic        validD1 = 1'b0;
    logic        validD2 = 1'b0;

    // Debug read expectation
    logic        dbgCheck = 1'b0;
    logic [31:0] dbgExp = '0;

    logic [4:0] lastDest = '0;
    int         errorCount = 0;
    int         issuedCount = 0;
    int         cycleCount = 0;

    regCluster u_dut (
        .Clock       (Clock),
        .rstN        (rstN),
        .instrValid  (instrValid),
        .instr       (instr),
        .dbgAddr     (dbgAddr),
        .result      (result),
        .resultDest  (resultDest),
        .resultValid (resultValid),
        .dbgData     (dbgData)
    );

    always #(CLOCK_PERIOD / 2) Clock = ~Clock;

    // Two-stage delay of the expectation
    always @(posedge Clock) begin
        expResultD1 <= expResult;
        expResultD2 <= expResultD1;
        expDestD1   <= expDest;
        expDestD2   <= expDestD1;
        destKnownD1 <= destKnown && instrValid;
        destKnownD2 <= destKnownD1;
        validD1     <= instrValid;
        validD2     <= validD1;
    end

    // Run limit
    always @(posedge Clock) begin
        cycleCount++;
        if (cycleCount >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, the run did not complete", cycleCount);
            $display("TB FAILED");
            $finish;
        end
    end

    aResultValue: assert property (@(posedge Clock) disable iff (!rstN)
        resultValid |-> (result == expResultD2))
    else begin
        errorCount++;
        $display("ERROR %0t result got %h expected %h",
            $time, $sampled(result), $sampled(expResultD2));
    end

    aResultDest: assert property (@(posedge Clock) disable iff (!rstN)
        (resultValid && destKnownD2) |-> (resultDest == expDestD2))
    else begin
        errorCount++;
        $display("ERROR %0t resultDest got %0d expected %0d",
            $time, $sampled(resultDest), $sampled(expDestD2));
    end

    // One cycle from the sampling edge to the strobe
    aResultStrobe: assert property (@(posedge Clock) disable iff (!rstN)
        resultValid == validD2)
    else begin
        errorCount++;
        $display("ERROR %0t resultValid got %b expected %b",
            $time, $sampled(resultValid), $sampled(validD2));
    end

    aDebugRead: assert property (@(posedge Clock) disable iff (!rstN)
        dbgCheck |-> (dbgData == dbgExp))
    else begin
        errorCount++;
        $display("ERROR %0t dbgData[%0d] got %h expected %h",
            $time, $sampled(dbgAddr), $sampled(dbgData), $sampled(dbgExp));
    end

    aResetQuiet: assert property (@(posedge Clock)
        !rstN |=> (!resultValid && !u_dut.regs.wrEn))
    else begin
        errorCount++;
        $display("Strobe or write port active right after a reset cycle at %0t", $time);
    end

    aNoZeroWrite: assert property (@(posedge Clock) disable iff (!rstN)
        u_dut.regs.wrEn |-> (u_dut.regs.wrAddr != '0))
    else begin
        errorCount++;
        $display("Register 0 was written at %0t", $time);
    end

    function automatic logic [31:0] rType(input logic [5:0] fn, input logic [4:0] rs,
                                          input logic [4:0] rt, input logic [4:0] rd);
        return {OPC_RTYPE, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic logic [31:0] iType(input logic [5:0] opc, input logic [4:0] rs,
                                          input logic [4:0] rt, input logic [15:0] imm);
        return {opc, rs, rt, imm};
    endfunction

    // Predict the outcome from the model, then drive the word
    task automatic issueInstr(input logic [31:0] word);
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  dst;
        logic [31:0] opA;
        logic [31:0] opB;
        logic [31:0] val;
        logic        isNop;
        logic        knownDest;
        rs = word[25:21];
        rt = word[20:16];
        dst = word[15:11];
        opA = modelRegs[rs];
        opB = modelRegs[rt];
        val = '0;
        isNop = 1'b0;
        knownDest = 1'b1;
        case (word[31:26])
            OPC_RTYPE: begin
                case (word[5:0])
                    FN_ADD:  val = opA + opB;
                    FN_SUB:  val = opA - opB;
                    FN_AND:  val = opA & opB;
                    FN_OR:   val = opA | opB;
                    FN_SLT:  val = ($signed(opA) < $signed(opB)) ? 32'd1 : 32'd0;
                    default: isNop = 1'b1;
                endcase
            end
            OPC_ADDI: begin
                dst = rt;
                val = opA + {{16{word[15]}}, word[15:0]};
            end
            OPC_ORI: begin
                dst = rt;
                val = opA | {16'h0000, word[15:0]};
            end
            default: begin
                // Destination field has no meaning here
                isNop = 1'b1;
                knownDest = 1'b0;
            end
        endcase
        if (!isNop && (dst != 5'd0)) begin
            modelRegs[dst] = val;
        end
        lastDest = dst;
        issuedCount++;
        @(posedge Clock);
        #DRIVE_DELAY;
        instr = word;
        instrValid = 1'b1;
        expResult = val;
        expDest = dst;
        destKnown = knownDest;
    endtask

    task automatic idleCycles(input int count);
        repeat (count) begin
            @(posedge Clock);
            #DRIVE_DELAY;
            instrValid = 1'b0;
        end
    endtask

    // Read back every register over the debug port
    task automatic sweepRegs();
        for (int a = 0; a < `REG_COUNT; a++) begin
            @(posedge Clock);
            #DRIVE_DELAY;
            instrValid = 1'b0;
            dbgAddr = a[4:0];
            dbgExp = modelRegs[a];
            dbgCheck = 1'b1;
        end
        @(posedge Clock);
        #DRIVE_DELAY;
        dbgCheck = 1'b0;
    endtask

    // Mixed stream, half of the rs fields chained to the last destination
    task automatic runRandomStream();
        int unsigned kind;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  rd;
        logic [15:0] imm;
        for (int n = 0; n < RANDOM_COUNT; n++) begin
            kind = $urandom % 10;
            rs = ($urandom % 2 == 0) ? lastDest : 5'($urandom % 32);
            rt = 5'($urandom % 32);
            rd = 5'($urandom % 32);
            imm = 16'($urandom);
            case (kind)
                0: issueInstr(rType(FN_ADD, rs, rt, rd));
                1: issueInstr(rType(FN_SUB, rs, rt, rd));
                2: issueInstr(rType(FN_AND, rs, rt, rd));
                3: issueInstr(rType(FN_OR, rs, rt, rd));
                4: issueInstr(rType(FN_SLT, rs, rt, rd));
                5: issueInstr(iType(OPC_ADDI, rs, rt, imm));
                6: issueInstr(iType(OPC_ORI, rs, rt, imm));
                7: issueInstr(rType(FN_NOR, rs, rt, rd));
                8: issueInstr(iType(OPC_LW, rs, rt, imm));
                default: issueInstr(rType(FN_ADD, rs, rt, 5'd0));
            endcase
            if ($urandom % 8 == 0) begin
                idleCycles(1);
            end
        end
    endtask

    initial begin
        void'($urandom(SEED));
        rstN = 1'b0;
        instrValid = 1'b0;
        instr = '0;
        dbgAddr = '0;
        // Register i starts as i, the stack pointer as its own value
        for (int i = 0; i < 32; i++) begin
            modelRegs[i] = i;
        end
        modelRegs[29] = STACK_VALUE;

        repeat (RESET_CYCLES) @(posedge Clock);
        #DRIVE_DELAY;
        rstN = 1'b1;

        // Reset values
        sweepRegs();

        // Every operation, signed compare with a negative operand
        issueInstr(iType(OPC_ADDI, 5'd0, 5'd7, 16'hfff0));
        issueInstr(rType(FN_ADD, 5'd3, 5'd29, 5'd5));
        issueInstr(rType(FN_SUB, 5'd2, 5'd29, 5'd6));
        issueInstr(rType(FN_AND, 5'd29, 5'd31, 5'd13));
        issueInstr(rType(FN_OR, 5'd12, 5'd17, 5'd14));
        issueInstr(rType(FN_SLT, 5'd7, 5'd1, 5'd8));
        issueInstr(rType(FN_SLT, 5'd1, 5'd7, 5'd9));
        issueInstr(rType(FN_SLT, 5'd6, 5'd5, 5'd15));
        // Same immediate, sign-extended versus zero-extended
        issueInstr(iType(OPC_ADDI, 5'd20, 5'd16, 16'h8001));
        issueInstr(iType(OPC_ORI, 5'd21, 5'd18, 16'h8001));
        idleCycles(DRAIN_CYCLES);
        sweepRegs();

        // Back-to-back dependent chain
        issueInstr(iType(OPC_ADDI, 5'd0, 5'd10, 16'd100));
        issueInstr(rType(FN_ADD, 5'd10, 5'd10, 5'd11));
        issueInstr(rType(FN_SUB, 5'd11, 5'd10, 5'd12));
        issueInstr(rType(FN_SLT, 5'd12, 5'd11, 5'd19));
        issueInstr(iType(OPC_ORI, 5'd19, 5'd19, 16'hf000));

        // Nothing below may change the file
        issueInstr(rType(FN_NOR, 5'd1, 5'd2, 5'd3));
        issueInstr(iType(OPC_LW, 5'd4, 5'd5, 16'h0010));
        issueInstr(rType(FN_ADD, 5'd1, 5'd2, 5'd0));
        issueInstr(iType(OPC_ADDI, 5'd3, 5'd0, 16'h0055));
        issueInstr(iType(OPC_ORI, 5'd4, 5'd0, 16'hffff));
        idleCycles(DRAIN_CYCLES);
        sweepRegs();

        runRandomStream();
        idleCycles(DRAIN_CYCLES);
        sweepRegs();
        idleCycles(1);

        $display("Summary: %0d errors, %0d instructions, %0d cycles",
            errorCount, issuedCount, cycleCount);
        if (errorCount == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verif/regCluster_sva.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "regcluster_config.svh"

module regCluster_sva (
    input logic                       Clock,
    input logic                       rstN,
    input logic                       instrValid,
    input logic                       resultValid,
    input logic                       wrEn,
    input logic [`REG_ADDR_WIDTH-1:0] wrAddr
);

    // Reset keeps the result strobe and the write port quiet
    // Checked one edge later so the asynchronous clear has settled
    aResetQuiet: assert property (
        @(posedge Clock) !rstN |=> (!resultValid && !wrEn)
    );

    // Register 0 is constant, so the write port never targets it
    aNoZeroWrite: assert property (
        @(posedge Clock) disable iff (!rstN)
        wrEn |-> (wrAddr != '0)
    );

    // Sampled at E0, decoded after E0, result strobe after E1
    // Seen from the sampling edges that is two samples apart
    aStrobeLatency: assert property (
        @(posedge Clock) disable iff (!rstN)
        resultValid == $past(instrValid, 2)
    );

endmodule

// Write port comes from the interface inside the top level
bind regCluster regCluster_sva uSva (
    .Clock       (Clock),
    .rstN        (rstN),
    .instrValid  (instrValid),
    .resultValid (resultValid),
    .wrEn        (regs.wrEn),
    .wrAddr      (regs.wrAddr)
);

`default_nettype wire

// ==== hw/regCluster.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "regcluster_config.svh"

module regCluster (
    input  logic                       Clock,
    input  logic                       rstN,
    input  logic                       instrValid,
    input  logic [31:0]                instr,
    input  logic [`REG_ADDR_WIDTH-1:0] dbgAddr,
    output logic [`DATA_WIDTH-1:0]     result,
    output logic [`REG_ADDR_WIDTH-1:0] resultDest,
    output logic                       resultValid,
    output logic [`DATA_WIDTH-1:0]     dbgData
);

    import regcluster_pkg::*;

    // Decode to execute
    decodedT decoded;
    logic    decodedValid;

    // Per-bank read data, indexed by bank number
    logic [`DATA_WIDTH-1:0] rsBankData [`BANK_COUNT];
    logic [`DATA_WIDTH-1:0] rtBankData [`BANK_COUNT];
    logic [`DATA_WIDTH-1:0] dbgBankData [`BANK_COUNT];

    // Read addresses and write port shared by all banks
    regPortIf regs ();

    instrDecode uDecode (
        .Clock        (Clock),
        .rstN         (rstN),
        .instrValid   (instrValid),
        .instr        (instr),
        .regs         (regs.decodeSide),
        .decoded      (decoded),
        .decodedValid (decodedValid)
    );

    // Register file, one bank per slice of the address space
    for (genvar g = 0; g < `BANK_COUNT; g++) begin : genBank
        regBank #(
            .BANK_ID (g)
        ) uBank (
            .Clock   (Clock),
            .rstN    (rstN),
            .regs    (regs.bankSide),
            .dbgAddr (dbgAddr),
            .rsData  (rsBankData[g]),
            .rtData  (rtBankData[g]),
            .dbgData (dbgBankData[g])
        );
    end

    aluWriteback uAluWb (
        .Clock        (Clock),
        .rstN         (rstN),
        .decoded      (decoded),
        .decodedValid (decodedValid),
        .rsBankData   (rsBankData),
        .rtBankData   (rtBankData),
        .dbgBankData  (dbgBankData),
        .dbgAddr      (dbgAddr),
        .regs         (regs.writeSide),
        .result       (result),
        .resultDest   (resultDest),
        .resultValid  (resultValid),
        .dbgData      (dbgData)
    );

endmodule

`default_nettype wire

// ==== hw/aluWriteback.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "regcluster_config.svh"

module aluWriteback (
    input  logic                       Clock,
    input  logic                       rstN,
    input  regcluster_pkg::decodedT    decoded,
    input  logic                       decodedValid,
    input  logic [`DATA_WIDTH-1:0]     rsBankData [`BANK_COUNT],
    input  logic [`DATA_WIDTH-1:0]     rtBankData [`BANK_COUNT],
    input  logic [`DATA_WIDTH-1:0]     dbgBankData [`BANK_COUNT],
    input  logic [`REG_ADDR_WIDTH-1:0] dbgAddr,
    regPortIf.writeSide                regs,
    output logic [`DATA_WIDTH-1:0]     result,
    output logic [`REG_ADDR_WIDTH-1:0] resultDest,
    output logic                       resultValid,
    output logic [`DATA_WIDTH-1:0]     dbgData
);

    import regcluster_pkg::*;

    // Upper address bits name the bank
    localparam int unsigned SEL_BITS = $clog2(`BANK_COUNT);
    localparam int unsigned SEL_LSB  = `REG_ADDR_WIDTH - SEL_BITS;

    logic [SEL_BITS-1:0] rsBank;
    logic [SEL_BITS-1:0] rtBank;
    logic [SEL_BITS-1:0] dbgBank;

    // ALU operands and combinational result
    logic [`DATA_WIDTH-1:0] opA;
    logic [`DATA_WIDTH-1:0] opB;
    logic [`DATA_WIDTH-1:0] aluOut;

    assign rsBank  = decoded.rs[`REG_ADDR_WIDTH-1:SEL_LSB];
    assign rtBank  = decoded.rt[`REG_ADDR_WIDTH-1:SEL_LSB];
    assign dbgBank = dbgAddr[`REG_ADDR_WIDTH-1:SEL_LSB];

    // Operand B is rt or the extended immediate
    assign opA = rsBankData[rsBank];
    assign opB = decoded.useImm ? decoded.imm : rtBankData[rtBank];

    always_comb begin
        case (decoded.op)
            opAdd:   aluOut = opA + opB;
            opSub:   aluOut = opA - opB;
            opAnd:   aluOut = opA & opB;
            opOr:    aluOut = opA | opB;
            // Signed compare, result is 0 or 1
            opSlt:   aluOut = {{(`DATA_WIDTH - 1){1'b0}}, ($signed(opA) < $signed(opB))};
            default: aluOut = '0;
        endcase
    end

    // Result strobe, exactly one cycle after the decode strobe
    always_ff @(posedge Clock or negedge rstN) begin
        if (!rstN) begin
            resultValid <= 1'b0;
        end else begin
            resultValid <= decodedValid;
        end
    end

    // Result payload holds between strobes
    always_ff @(posedge Clock) begin
        if (decodedValid) begin
            result     <= aluOut;
            resultDest <= decoded.dest;
        end
    end

    // Write lands on the same edge that captures result
    // Next instruction reads its operands after that edge, so no forwarding
    assign regs.wrEn   = decodedValid && decoded.writeEn;
    assign regs.wrAddr = decoded.dest;
    assign regs.wrData = aluOut;

    // Debug read port
    assign dbgData = dbgBankData[dbgBank];

endmodule

`default_nettype wire

// ==== hw/regBank.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "regcluster_config.svh"

module regBank #(
    parameter int unsigned BANK_ID = 0
) (
    input  logic                       Clock,
    input  logic                       rstN,
    regPortIf.bankSide                 regs,
    input  logic [`REG_ADDR_WIDTH-1:0] dbgAddr,
    output logic [`DATA_WIDTH-1:0]     rsData,
    output logic [`DATA_WIDTH-1:0]     rtData,
    output logic [`DATA_WIDTH-1:0]     dbgData
);

    // Low address bits pick the entry, high bits pick the bank
    localparam int unsigned LOW_BITS  = $clog2(`BANK_SIZE);
    localparam int unsigned HIGH_BITS = `REG_ADDR_WIDTH - LOW_BITS;
    localparam logic [HIGH_BITS-1:0] BANK_SEL = HIGH_BITS'(BANK_ID);

    logic [`DATA_WIDTH-1:0] bankRegs [`BANK_SIZE];

    // Write aimed at this bank
    logic bankHit;

    assign bankHit = regs.wrEn && (regs.wrAddr[`REG_ADDR_WIDTH-1:LOW_BITS] == BANK_SEL);

    for (genvar e = 0; e < `BANK_SIZE; e++) begin : genEntry
        // Global register number of this entry
        localparam int unsigned GLOBAL_IDX = BANK_ID * `BANK_SIZE + e;
        localparam logic [LOW_BITS-1:0] ENTRY_SEL = LOW_BITS'(e);
        // Register i resets to i, stack pointer to its own value
        localparam logic [`DATA_WIDTH-1:0] RESET_VAL =
            (GLOBAL_IDX == `STACK_REG) ? `STACK_RESET : GLOBAL_IDX;

        always_ff @(posedge Clock or negedge rstN) begin
            if (!rstN) begin
                bankRegs[e] <= RESET_VAL;
            end else if (bankHit && (regs.wrAddr[LOW_BITS-1:0] == ENTRY_SEL)) begin
                bankRegs[e] <= regs.wrData;
            end
        end
    end

    // Asynchronous reads
    // Top bits are resolved by the reader selecting among banks
    assign rsData  = bankRegs[regs.rsAddr[LOW_BITS-1:0]];
    assign rtData  = bankRegs[regs.rtAddr[LOW_BITS-1:0]];
    assign dbgData = bankRegs[dbgAddr[LOW_BITS-1:0]];

endmodule

`default_nettype wire

// ==== hw/instrDecode.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "regcluster_config.svh"

module instrDecode (
    input  logic                    Clock,
    input  logic                    rstN,
    input  logic                    instrValid,
    input  logic [31:0]             instr,
    regPortIf.decodeSide            regs,
    output regcluster_pkg::decodedT decoded,
    output logic                    decodedValid
);

    import regcluster_pkg::*;

    // MIPS primary opcodes
    localparam logic [5:0] OPC_RTYPE = 6'h00;
    localparam logic [5:0] OPC_ADDI  = 6'h08;
    localparam logic [5:0] OPC_ORI   = 6'h0d;

    // R-type funct codes
    localparam logic [5:0] FN_ADD = 6'h20;
    localparam logic [5:0] FN_SUB = 6'h22;
    localparam logic [5:0] FN_AND = 6'h24;
    localparam logic [5:0] FN_OR  = 6'h25;
    localparam logic [5:0] FN_SLT = 6'h2a;

    // Captured instruction word
    logic [31:0] instrQ;

    // Instruction fields
    logic [5:0]                 opcode;
    logic [5:0]                 funct;
    logic [`REG_ADDR_WIDTH-1:0] rsField;
    logic [`REG_ADDR_WIDTH-1:0] rtField;
    logic [`REG_ADDR_WIDTH-1:0] rdField;
    logic [15:0]                immField;

    // Valid strobe, one cycle behind instrValid
    always_ff @(posedge Clock or negedge rstN) begin
        if (!rstN) begin
            decodedValid <= 1'b0;
        end else begin
            decodedValid <= instrValid;
        end
    end

    // Word held until the next strobe
    always_ff @(posedge Clock) begin
        if (instrValid) begin
            instrQ <= instr;
        end
    end

    // Standard MIPS field positions
    assign opcode   = instrQ[31:26];
    assign rsField  = instrQ[25:21];
    assign rtField  = instrQ[20:16];
    assign rdField  = instrQ[15:11];
    assign funct    = instrQ[5:0];
    assign immField = instrQ[15:0];

    always_comb begin
        // Defaults describe an R-type no-op
        decoded.op     = opNop;
        decoded.rs     = rsField;
        decoded.rt     = rtField;
        decoded.dest   = rdField;
        decoded.useImm = 1'b0;
        decoded.imm    = '0;
        case (opcode)
            OPC_RTYPE: begin
                case (funct)
                    FN_ADD:  decoded.op = opAdd;
                    FN_SUB:  decoded.op = opSub;
                    FN_AND:  decoded.op = opAnd;
                    FN_OR:   decoded.op = opOr;
                    FN_SLT:  decoded.op = opSlt;
                    default: decoded.op = opNop;
                endcase
            end
            OPC_ADDI: begin
                // Signed immediate, result goes to rt
                decoded.op     = opAdd;
                decoded.dest   = rtField;
                decoded.useImm = 1'b1;
                decoded.imm    = {{(`DATA_WIDTH - 16){immField[15]}}, immField};
            end
            OPC_ORI: begin
                // Logical immediate is zero-extended
                decoded.op     = opOr;
                decoded.dest   = rtField;
                decoded.useImm = 1'b1;
                decoded.imm    = {{(`DATA_WIDTH - 16){1'b0}}, immField};
            end
            default: begin
                decoded.op = opNop;
            end
        endcase
        // Register 0 stays constant, no-ops write nothing
        decoded.writeEn = (decoded.op != opNop) && (decoded.dest != '0);
    end

    // Banks look up both sources during the cycle after capture
    assign regs.rsAddr = rsField;
    assign regs.rtAddr = rtField;

endmodule

`default_nettype wire

// ==== hw/regPortIf.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "regcluster_config.svh"

// Register file traffic between decoder, banks and writeback
interface regPortIf;

    // Read addresses, driven from the current decode
    logic [`REG_ADDR_WIDTH-1:0] rsAddr;
    logic [`REG_ADDR_WIDTH-1:0] rtAddr;

    // Single write port, taken at the rising edge while wrEn is high
    logic                       wrEn;
    logic [`REG_ADDR_WIDTH-1:0] wrAddr;
    logic [`DATA_WIDTH-1:0]     wrData;

    // Decoder names the source registers
    modport decodeSide (
        output rsAddr,
        output rtAddr
    );

    // ALU/writeback stage owns the write port
    modport writeSide (
        output wrEn,
        output wrAddr,
        output wrData
    );

    // Every bank sees reads and writes, and filters by its own address range
    modport bankSide (
        input rsAddr,
        input rtAddr,
        input wrEn,
        input wrAddr,
        input wrData
    );

endinterface

`default_nettype wire

// ==== hw/regcluster_pkg.sv ====
`default_nettype none

`include "regcluster_config.svh"

package regcluster_pkg;

    // ALU operations understood by the execute stage
    // opNop covers every encoding outside the supported subset
    typedef enum logic [2:0] {
        opAdd,
        opSub,
        opAnd,
        opOr,
        opSlt,
        opNop
    } aluOpE;

    // One decoded instruction, as seen by the ALU/writeback stage
    typedef struct packed {
        aluOpE                      op;
        logic [`REG_ADDR_WIDTH-1:0] rs;
        logic [`REG_ADDR_WIDTH-1:0] rt;
        // rd for R-type, rt for I-type
        logic [`REG_ADDR_WIDTH-1:0] dest;
        // Second operand comes from imm instead of rt
        logic                       useImm;
        logic [`DATA_WIDTH-1:0]     imm;
        // Low for no-ops and for destination 0
        logic                       writeEn;
    } decodedT;

endpackage

`default_nettype wire

// ==== include/regcluster_config.svh ====
`ifndef REGCLUSTER_CONFIG_SVH
`define REGCLUSTER_CONFIG_SVH

// Width of every register and of the ALU datapath
`define DATA_WIDTH 32

// Architectural register count and its address width
`define REG_COUNT 32
`define REG_ADDR_WIDTH $clog2(`REG_COUNT)

// Register file split into equal banks
`define BANK_COUNT 4
`define BANK_SIZE (`REG_COUNT / `BANK_COUNT)

// Stack pointer register and its value after reset
`define STACK_REG 29
`define STACK_RESET 54400

`endif
